/* source/bus_pkg.sv */
/*
 * Wishbone bus definitions shared by the masters, the arbiter and the RAM.
 * Widths are in words, so one address selects one 16-bit word.
 */

package bus_pkg;

    localparam int ADR_W = 13; // Word address width
    localparam int DAT_W = 16; // Bus data width

    // Word address into program RAM
    typedef logic [ADR_W-1:0] adr_t;

    // One bus data word
    typedef logic [DAT_W-1:0] dat_t;

    // Current bus owner held by the arbiter
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_CPU,
        GNT_HOST
    } grant_e;

endpackage

/* source/isa_pkg.sv */
/*
 * Instruction set definitions for the CPU core.
 * Fields: opcode 15:12, rd 11:9, ra 6:4, rb 2:0, imm 7:0, jump target 11:0.
 * Opcodes not listed in opcode_e execute as NOP.
 */

package isa_pkg;

    localparam int NUM_REGS = 8; // General purpose registers

    // One instruction word
    typedef logic [15:0] instr_t;

    // Register number
    typedef logic [2:0] reg_idx_t;

    // Program counter, one word address
    typedef logic [12:0] pc_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_LDI  = 4'd4,
        OP_AND  = 4'd5,
        OP_XOR  = 4'd6,
        OP_JMP  = 4'd13,
        OP_HALT = 4'd15
    } opcode_e;

    // Core sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_HALT
    } core_state_e;

endpackage

/* source/cpu_core.sv */
/*
 * Fetch and execute CPU with eight 16-bit registers.
 * Each instruction is read over a Wishbone classic master port, then
 * executed in the cycle after ack. HALT stops the core until reset.
 */

`timescale 1ns/10ps

module cpu_core (
    input  logic            clk,
    input  logic            pon_rst_n_i,
    input  logic            run_i,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output bus_pkg::adr_t   wb_adr_o,
    input  bus_pkg::dat_t   wb_dat_i,
    input  logic            wb_ack_i,
    output isa_pkg::pc_t    pc_o,
    output bus_pkg::dat_t   r6_o,
    output logic            halt_o
);

    isa_pkg::core_state_e state_q;
    isa_pkg::core_state_e state_d;
    isa_pkg::pc_t         pc_q;
    isa_pkg::pc_t         pc_d;
    isa_pkg::instr_t      instr_q;
    isa_pkg::opcode_e     opcode;
    isa_pkg::reg_idx_t    rd;
    isa_pkg::reg_idx_t    ra;
    isa_pkg::reg_idx_t    rb;
    bus_pkg::dat_t        regs [isa_pkg::NUM_REGS];
    bus_pkg::dat_t        op_a;
    bus_pkg::dat_t        op_b;
    bus_pkg::dat_t        rf_wdat;
    logic                 rf_we;

    // Instruction fields
    assign opcode = isa_pkg::opcode_e'(instr_q[15:12]);
    assign rd     = instr_q[11:9];
    assign ra     = instr_q[6:4];
    assign rb     = instr_q[2:0];
    assign op_a   = regs[ra];
    assign op_b   = regs[rb];

    // Fetch is always a read at the PC
    assign wb_cyc_o = (state_q == isa_pkg::ST_FETCH);
    assign wb_stb_o = (state_q == isa_pkg::ST_FETCH);
    assign wb_adr_o = pc_q;
    assign halt_o   = (state_q == isa_pkg::ST_HALT);

    // Execute datapath
    always_comb begin
        pc_d    = pc_q + 13'd1;
        rf_we   = 1'b0;
        rf_wdat = '0;
        case (opcode)
            isa_pkg::OP_ADD: begin
                rf_we   = 1'b1;
                rf_wdat = op_a + op_b;
            end
            isa_pkg::OP_SUB: begin
                rf_we   = 1'b1;
                rf_wdat = op_a - op_b;
            end
            isa_pkg::OP_LDI: begin
                rf_we   = 1'b1;
                rf_wdat = {8'h00, instr_q[7:0]}; // Zero extended
            end
            isa_pkg::OP_AND: begin
                rf_we   = 1'b1;
                rf_wdat = op_a & op_b;
            end
            isa_pkg::OP_XOR: begin
                rf_we   = 1'b1;
                rf_wdat = op_a ^ op_b;
            end
            isa_pkg::OP_JMP:  pc_d = {1'b0, instr_q[11:0]};
            isa_pkg::OP_HALT: pc_d = pc_q; // PC stays on the HALT word
            isa_pkg::OP_NOP:  pc_d = pc_q + 13'd1;
            default:          pc_d = pc_q + 13'd1; // Undefined opcodes
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            isa_pkg::ST_IDLE: begin
                if (run_i) state_d = isa_pkg::ST_FETCH;
            end
            isa_pkg::ST_FETCH: begin
                if (wb_ack_i) state_d = isa_pkg::ST_EXEC;
            end
            isa_pkg::ST_EXEC: begin
                if (opcode == isa_pkg::OP_HALT) state_d = isa_pkg::ST_HALT;
                else if (run_i)                 state_d = isa_pkg::ST_FETCH;
                else                            state_d = isa_pkg::ST_IDLE;
            end
            default: state_d = isa_pkg::ST_HALT; // Only reset leaves
        endcase
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q <= isa_pkg::ST_IDLE;
            pc_q    <= '0;
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            state_q <= state_d;
            if (state_q == isa_pkg::ST_EXEC) begin
                pc_q <= pc_d;
                if (rf_we) regs[rd] <= rf_wdat;
            end
        end
    end

    // Fetched word, valid in the ack cycle
    always_ff @(posedge clk) begin
        if (wb_cyc_o && wb_ack_i) instr_q <= wb_dat_i;
    end

    // Status copies lag the architectural state by one cycle
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pc_o <= '0;
            r6_o <= '0;
        end else begin
            pc_o <= pc_q;
            r6_o <= regs[3'd6];
        end
    end

endmodule

/* source/host_port.sv */
/*
 * Host access port into program RAM.
 * A one-cycle request becomes one Wishbone classic cycle; host_done_o
 * pulses with the ack, and read data is presented in that same cycle.
 */

`timescale 1ns/10ps

module host_port (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    input  logic          host_req_i,
    input  logic          host_we_i,
    input  bus_pkg::adr_t host_adr_i,
    input  bus_pkg::dat_t host_wdat_i,
    output bus_pkg::dat_t host_rdat_o,
    output logic          host_busy_o,
    output logic          host_done_o,
    output logic          wb_cyc_o,
    output logic          wb_stb_o,
    output logic          wb_we_o,
    output bus_pkg::adr_t wb_adr_o,
    output bus_pkg::dat_t wb_dat_o,
    input  bus_pkg::dat_t wb_dat_i,
    input  logic          wb_ack_i
);

    logic          busy_q;
    logic          we_q;
    logic          accept;
    logic          done;
    bus_pkg::adr_t adr_q;
    bus_pkg::dat_t wdat_q;
    bus_pkg::dat_t rdat_q;

    assign accept = host_req_i & ~busy_q; // Requests while busy are ignored
    assign done   = busy_q & wb_ack_i;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0; // cyc drops the cycle after ack
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            we_q   <= host_we_i;
            adr_q  <= host_adr_i;
            wdat_q <= host_wdat_i;
        end
        if (done && !we_q) rdat_q <= wb_dat_i;
    end

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_we_o  = busy_q & we_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = wdat_q;

    assign host_busy_o = busy_q;
    assign host_done_o = done;
    // Bypass so the word is visible in the done cycle
    assign host_rdat_o = (done && !we_q) ? wb_dat_i : rdat_q;

endmodule

/* source/wb_arbiter.sv */
/*
 * Two-master Wishbone classic arbiter, CPU on master 0, host on master 1.
 * The bus is granted while idle, alternating when both request, and is
 * held until the owner drops cyc. Only the owner receives ack.
 */

`timescale 1ns/10ps

module wb_arbiter (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    input  logic          m0_cyc_i,
    input  logic          m0_stb_i,
    input  bus_pkg::adr_t m0_adr_i,
    output bus_pkg::dat_t m0_dat_o,
    output logic          m0_ack_o,
    input  logic          m1_cyc_i,
    input  logic          m1_stb_i,
    input  logic          m1_we_i,
    input  bus_pkg::adr_t m1_adr_i,
    input  bus_pkg::dat_t m1_dat_i,
    output bus_pkg::dat_t m1_dat_o,
    output logic          m1_ack_o,
    output logic          s_cyc_o,
    output logic          s_stb_o,
    output logic          s_we_o,
    output bus_pkg::adr_t s_adr_o,
    output bus_pkg::dat_t s_dat_o,
    input  bus_pkg::dat_t s_dat_i,
    input  logic          s_ack_i
);

    bus_pkg::grant_e owner_q;
    bus_pkg::grant_e owner_d;
    logic            last_host_q; // Host was served last
    logic            own_cpu;
    logic            own_host;

    always_comb begin
        owner_d = owner_q;
        case (owner_q)
            bus_pkg::GNT_CPU:  if (!m0_cyc_i) owner_d = bus_pkg::GNT_NONE;
            bus_pkg::GNT_HOST: if (!m1_cyc_i) owner_d = bus_pkg::GNT_NONE;
            default: begin
                if (m0_cyc_i && m1_cyc_i)
                    owner_d = last_host_q ? bus_pkg::GNT_CPU : bus_pkg::GNT_HOST;
                else if (m0_cyc_i)
                    owner_d = bus_pkg::GNT_CPU;
                else if (m1_cyc_i)
                    owner_d = bus_pkg::GNT_HOST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            owner_q     <= bus_pkg::GNT_NONE;
            last_host_q <= 1'b0;
        end else begin
            owner_q <= owner_d;
            if (owner_q == bus_pkg::GNT_NONE && owner_d != bus_pkg::GNT_NONE)
                last_host_q <= (owner_d == bus_pkg::GNT_HOST);
        end
    end

    assign own_cpu  = (owner_q == bus_pkg::GNT_CPU);
    assign own_host = (owner_q == bus_pkg::GNT_HOST);

    // Slave side follows the owner, quiet when nobody holds the grant
    assign s_cyc_o = (own_cpu & m0_cyc_i) | (own_host & m1_cyc_i);
    assign s_stb_o = (own_cpu & m0_stb_i) | (own_host & m1_stb_i);
    assign s_we_o  = own_host & m1_we_i; // CPU only reads
    assign s_adr_o = own_host ? m1_adr_i : m0_adr_i;
    assign s_dat_o = m1_dat_i;

    assign m0_dat_o = s_dat_i;
    assign m1_dat_o = s_dat_i;
    assign m0_ack_o = own_cpu & s_ack_i;
    assign m1_ack_o = own_host & s_ack_i;

endmodule

/* source/prog_ram.sv */
/*
 * Program memory as a Wishbone classic slave.
 * Every access gets a registered ack one cycle after stb; writes land at
 * the request edge and read data is valid with the ack.
 */

`timescale 1ns/10ps

module prog_ram #(
    parameter int DEPTH = 8192 // Power of two, at most 2**ADR_W
) (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    input  logic          wb_cyc_i,
    input  logic          wb_stb_i,
    input  logic          wb_we_i,
    input  bus_pkg::adr_t wb_adr_i,
    input  bus_pkg::dat_t wb_dat_i,
    output bus_pkg::dat_t wb_dat_o,
    output logic          wb_ack_o
);

    localparam int AW = $clog2(DEPTH);

    bus_pkg::dat_t mem [DEPTH];
    bus_pkg::dat_t rdat_q;
    logic          ack_q;
    logic          req;
    logic [AW-1:0] idx;

    assign idx = wb_adr_i[AW-1:0];
    assign req = wb_cyc_i & wb_stb_i & ~ack_q; // No back-to-back acks

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) ack_q <= 1'b0;
        else              ack_q <= req;
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (wb_we_i) mem[idx] <= wb_dat_i;
            rdat_q <= mem[idx];
        end
    end

    assign wb_dat_o = rdat_q;
    assign wb_ack_o = ack_q;

endmodule

/* source/cpu_subsys_top.sv */
/*
 * CPU subsystem top level.
 * The core and the host port share program RAM through the arbiter;
 * PC, R6 and the halt flag are brought out for observation.
 */

`timescale 1ns/10ps

module cpu_subsys_top (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    input  logic          run_i,
    input  logic          host_req_i,
    input  logic          host_we_i,
    input  bus_pkg::adr_t host_adr_i,
    input  bus_pkg::dat_t host_wdat_i,
    output bus_pkg::dat_t host_rdat_o,
    output logic          host_busy_o,
    output logic          host_done_o,
    output isa_pkg::pc_t  pc_o,
    output bus_pkg::dat_t r6_o,
    output logic          halt_o
);

    // CPU master
    logic          cpu_cyc;
    logic          cpu_stb;
    bus_pkg::adr_t cpu_adr;
    bus_pkg::dat_t cpu_rdat;
    logic          cpu_ack;

    // Host master
    logic          hst_cyc;
    logic          hst_stb;
    logic          hst_we;
    bus_pkg::adr_t hst_adr;
    bus_pkg::dat_t hst_wdat;
    bus_pkg::dat_t hst_rdat;
    logic          hst_ack;

    // RAM slave
    logic          ram_cyc;
    logic          ram_stb;
    logic          ram_we;
    bus_pkg::adr_t ram_adr;
    bus_pkg::dat_t ram_wdat;
    bus_pkg::dat_t ram_rdat;
    logic          ram_ack;

    cpu_core u_core (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .run_i       (run_i),
        .wb_cyc_o    (cpu_cyc),
        .wb_stb_o    (cpu_stb),
        .wb_adr_o    (cpu_adr),
        .wb_dat_i    (cpu_rdat),
        .wb_ack_i    (cpu_ack),
        .pc_o        (pc_o),
        .r6_o        (r6_o),
        .halt_o      (halt_o)
    );

    host_port u_host (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .host_req_i  (host_req_i),
        .host_we_i   (host_we_i),
        .host_adr_i  (host_adr_i),
        .host_wdat_i (host_wdat_i),
        .host_rdat_o (host_rdat_o),
        .host_busy_o (host_busy_o),
        .host_done_o (host_done_o),
        .wb_cyc_o    (hst_cyc),
        .wb_stb_o    (hst_stb),
        .wb_we_o     (hst_we),
        .wb_adr_o    (hst_adr),
        .wb_dat_o    (hst_wdat),
        .wb_dat_i    (hst_rdat),
        .wb_ack_i    (hst_ack)
    );

    wb_arbiter u_arb (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .m0_cyc_i    (cpu_cyc),
        .m0_stb_i    (cpu_stb),
        .m0_adr_i    (cpu_adr),
        .m0_dat_o    (cpu_rdat),
        .m0_ack_o    (cpu_ack),
        .m1_cyc_i    (hst_cyc),
        .m1_stb_i    (hst_stb),
        .m1_we_i     (hst_we),
        .m1_adr_i    (hst_adr),
        .m1_dat_i    (hst_wdat),
        .m1_dat_o    (hst_rdat),
        .m1_ack_o    (hst_ack),
        .s_cyc_o     (ram_cyc),
        .s_stb_o     (ram_stb),
        .s_we_o      (ram_we),
        .s_adr_o     (ram_adr),
        .s_dat_o     (ram_wdat),
        .s_dat_i     (ram_rdat),
        .s_ack_i     (ram_ack)
    );

    // Full 13-bit word space
    prog_ram #(
        .DEPTH (1 << bus_pkg::ADR_W)
    ) u_ram (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .wb_cyc_i    (ram_cyc),
        .wb_stb_i    (ram_stb),
        .wb_we_i     (ram_we),
        .wb_adr_i    (ram_adr),
        .wb_dat_i    (ram_wdat),
        .wb_dat_o    (ram_rdat),
        .wb_ack_o    (ram_ack)
    );

endmodule

/* tests/cpu_subsys_asserts.sv */
/*
 * Wishbone protocol checker for the two-master arbiter.
 * Bound into every wb_arbiter instance; it watches both master ports,
 * the slave port and the grant register.
 */

`timescale 1ns/10ps

module cpu_subsys_asserts (
    input  logic            clk,
    input  logic            pon_rst_n_i,
    input  logic            m0_cyc_i,
    input  logic            m0_stb_i,
    input  bus_pkg::adr_t   m0_adr_i,
    input  logic            m0_ack_i,
    input  logic            m1_cyc_i,
    input  logic            m1_stb_i,
    input  logic            m1_we_i,
    input  bus_pkg::adr_t   m1_adr_i,
    input  bus_pkg::dat_t   m1_dat_i,
    input  logic            m1_ack_i,
    input  logic            s_stb_i,
    input  logic            s_ack_i,
    input  bus_pkg::grant_e owner_i
);

    // Slave only answers a live strobe
    a_slave_ack_stb: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        s_ack_i |-> s_stb_i)
        else $error("Slave ack without stb");

    // Ack returns to the requesting master that held the grant for the access
    a_cpu_ack_owner: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        m0_ack_i |-> m0_cyc_i && $past(owner_i) == bus_pkg::GNT_CPU)
        else $error("CPU received ack without grant");
    a_host_ack_owner: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        m1_ack_i |-> m1_cyc_i && $past(owner_i) == bus_pkg::GNT_HOST)
        else $error("Host received ack without grant");

    // Stalled masters keep their request steady
    a_cpu_hold: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        m0_cyc_i && !m0_ack_i |=> m0_cyc_i && m0_stb_i && $stable(m0_adr_i))
        else $error("CPU request changed before ack");
    a_host_hold: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        m1_cyc_i && !m1_ack_i |=> m1_cyc_i && m1_stb_i && $stable(m1_we_i)
            && $stable(m1_adr_i) && $stable(m1_dat_i))
        else $error("Host request changed before ack");

    // One-word cycles end right after ack
    a_cpu_drop: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        m0_ack_i |=> !m0_cyc_i)
        else $error("CPU kept cyc after ack");
    a_host_drop: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        m1_ack_i |=> !m1_cyc_i)
        else $error("Host kept cyc after ack");

endmodule

bind wb_arbiter cpu_subsys_asserts u_bus_asserts (
    .clk         (clk),
    .pon_rst_n_i (pon_rst_n_i),
    .m0_cyc_i    (m0_cyc_i),
    .m0_stb_i    (m0_stb_i),
    .m0_adr_i    (m0_adr_i),
    .m0_ack_i    (m0_ack_o),
    .m1_cyc_i    (m1_cyc_i),
    .m1_stb_i    (m1_stb_i),
    .m1_we_i     (m1_we_i),
    .m1_adr_i    (m1_adr_i),
    .m1_dat_i    (m1_dat_i),
    .m1_ack_i    (m1_ack_o),
    .s_stb_i     (s_stb_o),
    .s_ack_i     (s_ack_i),
    .owner_i     (owner_q)
);

/* tests/cpu_subsys_tb.sv */
/*
 * Testbench for the CPU subsystem.
 * Loads random programs through the host port, runs them on the core and
 * compares PC, R6 and halt with a reference ISA model in this module.
 */

`timescale 1ns/10ps

module cpu_subsys_tb;

    localparam int N_RW      = 24; // Host write/read-back pairs
    localparam int PROG_LEN  = 40; // Words per program, HALT last
    localparam int N_CONT    = 30; // Host reads while the CPU runs
    localparam int N_HOST    = 2 * N_RW + 3 * PROG_LEN + N_CONT;
    localparam int N_INSTR   = 3 * PROG_LEN;
    localparam int CYCLE_LIMIT = (N_HOST + N_INSTR) * 8 + 400;

    logic          clk = 1'b0;
    logic          pon_rst_n_i;
    logic          run_i;
    logic          host_req_i;
    logic          host_we_i;
    bus_pkg::adr_t host_adr_i;
    bus_pkg::dat_t host_wdat_i;
    bus_pkg::dat_t host_rdat_o;
    logic          host_busy_o;
    logic          host_done_o;
    isa_pkg::pc_t  pc_o;
    bus_pkg::dat_t r6_o;
    logic          halt_o;

    logic [31:0]   lfsr_q = 32'haf7ba686;
    int            cycle_cnt = 0;
    bus_pkg::dat_t prog [PROG_LEN];
    bus_pkg::adr_t rw_adr [N_RW];
    bus_pkg::dat_t rw_dat [N_RW];
    bus_pkg::dat_t exp_r6;
    isa_pkg::pc_t  exp_pc;
    logic          exp_halt;

    cpu_subsys_top DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        pon_rst_n_i <= 1'b0;
        run_i       <= 1'b0;
        repeat (8) @(posedge clk);
        pon_rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("reset_pc", 16'h0000, {3'b000, pc_o});
        check_value("reset_r6", 16'h0000, r6_o);
        check_value("reset_halt", 16'h0000, {15'd0, halt_o});
        check_value("reset_busy", 16'h0000, {15'd0, host_busy_o});
        check_value("reset_done", 16'h0000, {15'd0, host_done_o});
    endtask

    // One host request, returns once host_done_o has pulsed
    task automatic host_access(input logic we, input bus_pkg::adr_t adr,
                               input bus_pkg::dat_t wdat, output bus_pkg::dat_t rdat);
        @(negedge clk);
        while (host_busy_o) @(negedge clk);
        @(posedge clk);
        host_req_i  <= 1'b1;
        host_we_i   <= we;
        host_adr_i  <= adr;
        host_wdat_i <= wdat;
        @(posedge clk);
        host_req_i  <= 1'b0;
        @(negedge clk);
        check_value("host_busy", 16'h0001, {15'd0, host_busy_o}); // Busy right after req
        while (!host_done_o) @(negedge clk);
        rdat = host_rdat_o;
    endtask

    // Random body, forward jumps only, HALT in the last word
    function automatic void make_program(input bit jump_heavy);
        logic [2:0]    kind;
        bus_pkg::dat_t w;
        int            span;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            w    = bus_pkg::dat_t'(rand_bits(16));
            kind = 3'(rand_bits(3));
            if (jump_heavy && rand_bits(1) == 32'd1) kind = 3'd7;
            case (kind)
                3'd0, 3'd1: w[15:12] = isa_pkg::OP_LDI;
                3'd2: w[15:12] = isa_pkg::OP_ADD;
                3'd3: w[15:12] = isa_pkg::OP_SUB;
                3'd4: w[15:12] = isa_pkg::OP_AND;
                3'd5: w[15:12] = isa_pkg::OP_XOR;
                3'd6: begin
                    // Random opcode, mostly NOP or undefined
                    if (w[15:12] == isa_pkg::OP_JMP || w[15:12] == isa_pkg::OP_HALT)
                        w[15:12] = 4'd3;
                end
                default: begin
                    span     = PROG_LEN - 1 - i;
                    w[15:12] = isa_pkg::OP_JMP;
                    w[11:0]  = 12'(i + 1 + int'(rand_bits(8)) % span);
                end
            endcase
            prog[i] = w;
        end
        prog[PROG_LEN-1] = {isa_pkg::OP_HALT, 12'(rand_bits(12))};
    endfunction

    // Reference ISA interpreter
    function automatic void run_model();
        bus_pkg::dat_t regs [8];
        bus_pkg::dat_t w;
        bus_pkg::dat_t a;
        bus_pkg::dat_t b;
        logic [3:0]    op;
        int            pc;
        int            next;
        for (int r = 0; r < 8; r++) regs[r] = 16'h0000;
        pc       = 0;
        exp_halt = 1'b0;
        while (!exp_halt && pc < PROG_LEN) begin
            w    = prog[pc];
            op   = w[15:12];
            a    = regs[w[6:4]];
            b    = regs[w[2:0]];
            next = pc + 1;
            case (op)
                isa_pkg::OP_ADD: regs[w[11:9]] = a + b;
                isa_pkg::OP_SUB: regs[w[11:9]] = a - b;
                isa_pkg::OP_LDI: regs[w[11:9]] = {8'h00, w[7:0]};
                isa_pkg::OP_AND: regs[w[11:9]] = a & b;
                isa_pkg::OP_XOR: regs[w[11:9]] = a ^ b;
                isa_pkg::OP_JMP: next = int'(w[11:0]);
                isa_pkg::OP_HALT: begin
                    exp_halt = 1'b1;
                    next     = pc;
                end
                default: ; // NOP and undefined
            endcase
            pc = next;
        end
        exp_pc = 13'(pc);
        exp_r6 = regs[6];
    endfunction

    task automatic load_program();
        bus_pkg::dat_t rdat;
        for (int i = 0; i < PROG_LEN; i++) begin
            host_access(1'b1, 13'(i), prog[i], rdat);
        end
    endtask

    task automatic finish_and_check(input string name);
        @(negedge clk);
        while (!halt_o) @(negedge clk);
        repeat (2) @(negedge clk); // Status copies lag by a cycle
        check_value({name, "_halt"}, {15'd0, exp_halt}, {15'd0, halt_o});
        check_value({name, "_pc"}, {3'b000, exp_pc}, {3'b000, pc_o});
        check_value({name, "_r6"}, exp_r6, r6_o);
        @(posedge clk);
        run_i <= 1'b0;
    endtask

    initial begin
        bus_pkg::dat_t rdat;
        bus_pkg::dat_t exp;
        bus_pkg::adr_t adr;
        pon_rst_n_i = 1'b0;
        run_i       = 1'b0;
        host_req_i  = 1'b0;
        host_we_i   = 1'b0;
        host_adr_i  = '0;
        host_wdat_i = '0;
        apply_reset();

        // Host write then read-back with the core idle
        for (int i = 0; i < N_RW; i++) begin
            rw_adr[i] = bus_pkg::adr_t'(rand_bits(13));
            rw_dat[i] = bus_pkg::dat_t'(rand_bits(16));
            host_access(1'b1, rw_adr[i], rw_dat[i], rdat);
        end
        for (int i = 0; i < N_RW; i++) begin
            exp = rw_dat[i];
            for (int j = i + 1; j < N_RW; j++) begin
                if (rw_adr[j] == rw_adr[i]) exp = rw_dat[j]; // Later write wins
            end
            host_access(1'b0, rw_adr[i], 16'h0000, rdat);
            check_value("host_readback", exp, rdat);
        end

        make_program(1'b0);
        run_model();
        load_program();
        @(posedge clk);
        run_i <= 1'b1;
        finish_and_check("rand_prog");

        apply_reset();
        make_program(1'b1);
        run_model();
        load_program();
        @(posedge clk);
        run_i <= 1'b1;
        finish_and_check("jump_prog");

        // Host reads compete with instruction fetch
        apply_reset();
        make_program(1'b0);
        run_model();
        load_program();
        @(posedge clk);
        run_i <= 1'b1;
        for (int k = 0; k < N_CONT; k++) begin
            adr = bus_pkg::adr_t'(int'(rand_bits(8)) % PROG_LEN);
            host_access(1'b0, adr, 16'h0000, rdat);
            check_value("contention_read", prog[adr], rdat);
        end
        finish_and_check("contention_prog");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* flist.f */
source/bus_pkg.sv
source/isa_pkg.sv
source/cpu_core.sv
source/host_port.sv
source/wb_arbiter.sv
source/prog_ram.sv
source/cpu_subsys_top.sv
tests/cpu_subsys_asserts.sv
tests/cpu_subsys_tb.sv

/* Makefile */
# Verilator build and run for the CPU subsystem testbench

VERILATOR ?= verilator
TOP       ?= cpu_subsys_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
